// ==== dbg_macros.svh ====
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// ==============================
// Widths
// ==============================
`define DBG_SPPE_LANES   16
`define DBG_SPPE_W       12
`define DBG_LANE_SEL_W   4
`define DBG_WH_ADDR_W    14
`define DBG_FEAT_ADDR_W  16
`define DBG_CNT_W        48
`define DBG_APB_ADDR_W   8
`define DBG_APB_DATA_W   32
`define DBG_STAT_W       10

`define DBG_FEAT_LIMIT   16'd43328     // First out-of-range feature address
`define DBG_NUM_SPARSE   32'd12
`define DBG_ID           32'd14192503

// ==============================
// Register map
// ==============================
`define DBG_REG_ID       8'h00
`define DBG_REG_CONFIG   8'h04
`define DBG_REG_STATUS   8'h08
`define DBG_REG_CNT_LO   8'h0C
`define DBG_REG_CNT_HI   8'h10
`define DBG_REG_CAP_CFG  8'h14
`define DBG_REG_CAP_A    8'h18
`define DBG_REG_CAP_B    8'h1C

// STATUS bits, MSB first as the handshake order
`define DBG_ST_SPMM_VLD  7
`define DBG_ST_SPMM_RDY  6
`define DBG_ST_DMVM_VLD  5
`define DBG_ST_DMVM_RDY  4
`define DBG_ST_SM_VLD    3
`define DBG_ST_SM_RDY    2
`define DBG_ST_AGGR_VLD  1
`define DBG_ST_AGGR_RDY  0
`define DBG_ST_FEAT_WR   8
`define DBG_ST_FEAT_OVF  9

`endif

// ==== dbg_pkg.sv ====
`default_nettype none

`include "dbg_macros.svh"

package dbg_pkg;

  // ==============================
  // Bus types
  // ==============================
  typedef logic [`DBG_APB_DATA_W-1:0] apb_word_t;

  // ==============================
  // Capture configuration
  // ==============================
  typedef struct packed {
    logic [`DBG_WH_ADDR_W-1:0]  addr_a;    // Match address, slot A
    logic [`DBG_WH_ADDR_W-1:0]  addr_b;    // Match address, slot B
    logic [`DBG_LANE_SEL_W-1:0] lane_sel;  // PE lane to latch
  } cap_fields_t;

  // Same word as written over APB and as seen by the capture unit
  typedef union packed {
    apb_word_t   raw;
    cap_fields_t fields;
  } dbg_cap_cfg_u;

endpackage

`default_nettype wire

// ==== dbg_flag_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_macros.svh"

module dbg_flag_sampler (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        spmm_vld_i,
  input  logic                        spmm_rdy_i,
  input  logic                        dmvm_vld_i,
  input  logic                        dmvm_rdy_i,
  input  logic                        sm_vld_i,
  input  logic                        sm_rdy_i,
  input  logic                        aggr_vld_i,
  input  logic                        aggr_rdy_i,
  input  logic                        feat_ena_i,
  input  logic [`DBG_FEAT_ADDR_W-1:0] feat_addr_i,
  input  logic [`DBG_STAT_W-1:0]      flag_clr_i,
  output logic [`DBG_STAT_W-1:0]      flags_o
);

  logic [`DBG_STAT_W-1:0] flag_set;
  logic [`DBG_STAT_W-1:0] keep_mask;
  logic [`DBG_STAT_W-1:0] flags_q;
  logic                   feat_ovf;

  assign feat_ovf = feat_ena_i && (feat_addr_i >= `DBG_FEAT_LIMIT);

  // ==============================
  // Set events
  // ==============================
  always_comb begin
    flag_set                   = '0;
    flag_set[`DBG_ST_SPMM_VLD] = spmm_vld_i;
    flag_set[`DBG_ST_SPMM_RDY] = spmm_rdy_i;
    flag_set[`DBG_ST_DMVM_VLD] = dmvm_vld_i;
    flag_set[`DBG_ST_DMVM_RDY] = dmvm_rdy_i;
    flag_set[`DBG_ST_SM_VLD]   = sm_vld_i;
    flag_set[`DBG_ST_SM_RDY]   = sm_rdy_i;
    flag_set[`DBG_ST_AGGR_VLD] = aggr_vld_i;
    flag_set[`DBG_ST_AGGR_RDY] = aggr_rdy_i;
    flag_set[`DBG_ST_FEAT_WR]  = feat_ena_i;
    flag_set[`DBG_ST_FEAT_OVF] = feat_ovf;
  end

  assign keep_mask = flags_q & ~flag_clr_i;  // W1C mask

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= flag_set | keep_mask;  // Set beats clear
    end
  end

  assign flags_o = flags_q;

  // A held flag only drops when software clears it
  a_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    (($past(flags_q) & ~$past(flag_clr_i) & ~flags_q) == '0));

endmodule

`default_nettype wire

// ==== dbg_probe_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_macros.svh"

module dbg_probe_capture (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         sm_vld_i,
  input  logic                                         spmm_rdy_i,
  input  logic [`DBG_WH_ADDR_W-1:0]                    wh_addr_i,
  input  logic [`DBG_SPPE_LANES-1:0][`DBG_SPPE_W-1:0] sppe_i,
  input  logic                                         cnt_clr_i,
  input  dbg_pkg::dbg_cap_cfg_u                        cap_cfg_i,
  output logic [`DBG_CNT_W-1:0]                        sm_count_o,
  output logic [`DBG_SPPE_W-1:0]                       cap_a_o,
  output logic [`DBG_SPPE_W-1:0]                       cap_b_o
);

  // ==============================
  // Softmax activity counter
  // ==============================
  logic [`DBG_CNT_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (cnt_clr_i) begin
      cnt_q <= '0;  // Clear wins over a count
    end else if (sm_vld_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign sm_count_o = cnt_q;

  // ==============================
  // Lane capture slots
  // ==============================
  logic [1:0][`DBG_WH_ADDR_W-1:0] match_addr;  // Index 0 is slot A
  logic [1:0][`DBG_SPPE_W-1:0]    cap_q;
  logic [1:0]                     hit;
  logic [`DBG_SPPE_W-1:0]         lane_val;

  assign match_addr[0] = cap_cfg_i.fields.addr_a;
  assign match_addr[1] = cap_cfg_i.fields.addr_b;
  assign lane_val      = sppe_i[cap_cfg_i.fields.lane_sel];

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      hit[s] = spmm_rdy_i && (wh_addr_i == match_addr[s]);
    end
  end

  // Both slots may load in one cycle when A equals B
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_q <= '0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (hit[s]) begin
          cap_q[s] <= lane_val;
        end
      end
    end
  end

  assign cap_a_o = cap_q[0];
  assign cap_b_o = cap_q[1];

  // Counter only moves up between clears
  a_cnt_mono: assert property (@(posedge clk) disable iff (!rst_n)
    !cnt_clr_i |=> (cnt_q >= $past(cnt_q)));

  // Lane field must name a defined PE lane
  a_lane_rng: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(cap_cfg_i.fields.lane_sel));

endmodule

`default_nettype wire

// ==== dbg_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_macros.svh"

module dbg_apb_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`DBG_APB_ADDR_W-1:0] paddr_i,
  input  dbg_pkg::apb_word_t         pwdata_i,
  output dbg_pkg::apb_word_t         prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  input  logic [`DBG_STAT_W-1:0]     flags_i,
  input  logic [`DBG_CNT_W-1:0]      sm_count_i,
  input  logic [`DBG_SPPE_W-1:0]     cap_a_i,
  input  logic [`DBG_SPPE_W-1:0]     cap_b_i,
  output logic [`DBG_STAT_W-1:0]     flag_clr_o,
  output logic                       cnt_clr_o,
  output dbg_pkg::dbg_cap_cfg_u      cap_cfg_o
);

  import dbg_pkg::*;

  logic         access;
  logic         wr_en;
  logic         addr_hit;
  logic         wr_ok;
  apb_word_t    rdata;
  dbg_cap_cfg_u cap_cfg_q;

  assign access = psel_i && penable_i;  // Access phase

  // ==============================
  // Address decode and read mux
  // ==============================
  always_comb begin
    rdata    = '0;
    addr_hit = 1'b1;
    wr_ok    = 1'b0;
    case (paddr_i)
      `DBG_REG_ID:     rdata = `DBG_ID;
      `DBG_REG_CONFIG: rdata = `DBG_NUM_SPARSE;
      `DBG_REG_STATUS: begin
        rdata = apb_word_t'(flags_i);
        wr_ok = 1'b1;
      end
      `DBG_REG_CNT_LO: begin
        rdata = sm_count_i[`DBG_APB_DATA_W-1:0];
        wr_ok = 1'b1;  // Any write clears the counter
      end
      `DBG_REG_CNT_HI: rdata = apb_word_t'(sm_count_i[`DBG_CNT_W-1:`DBG_APB_DATA_W]);
      `DBG_REG_CAP_CFG: begin
        rdata = cap_cfg_q.raw;
        wr_ok = 1'b1;
      end
      `DBG_REG_CAP_A:  rdata = apb_word_t'(cap_a_i);
      `DBG_REG_CAP_B:  rdata = apb_word_t'(cap_b_i);
      default:         addr_hit = 1'b0;
    endcase
  end

  assign pslverr_o = access && (!addr_hit || (pwrite_i && !wr_ok));
  assign wr_en     = access && pwrite_i && wr_ok;
  assign prdata_o  = rdata;
  assign pready_o  = 1'b1;  // No wait states

  // ==============================
  // Writes and clear pulses
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_cfg_q <= '0;
    end else if (wr_en && (paddr_i == `DBG_REG_CAP_CFG)) begin
      cap_cfg_q.raw <= pwdata_i;
    end
  end

  assign flag_clr_o = (wr_en && (paddr_i == `DBG_REG_STATUS)) ?
                      pwdata_i[`DBG_STAT_W-1:0] : '0;
  assign cnt_clr_o  = wr_en && (paddr_i == `DBG_REG_CNT_LO);
  assign cap_cfg_o  = cap_cfg_q;

  // Access phase always follows a setup phase of the same transfer
  a_apb_seq: assert property (@(posedge clk) disable iff (!rst_n)
    penable_i |-> (psel_i && $past(psel_i && !penable_i)));

endmodule

`default_nettype wire

// ==== dbg_monitor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_macros.svh"

module dbg_monitor_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         spmm_vld_i,
  input  logic                                         spmm_rdy_i,
  input  logic                                         dmvm_vld_i,
  input  logic                                         dmvm_rdy_i,
  input  logic                                         sm_vld_i,
  input  logic                                         sm_rdy_i,
  input  logic                                         aggr_vld_i,
  input  logic                                         aggr_rdy_i,
  input  logic                                         feat_ena_i,
  input  logic [`DBG_FEAT_ADDR_W-1:0]                  feat_addr_i,
  input  logic [`DBG_WH_ADDR_W-1:0]                    wh_addr_i,
  input  logic [`DBG_SPPE_LANES-1:0][`DBG_SPPE_W-1:0] sppe_i,
  input  logic                                         psel_i,
  input  logic                                         penable_i,
  input  logic                                         pwrite_i,
  input  logic [`DBG_APB_ADDR_W-1:0]                   paddr_i,
  input  dbg_pkg::apb_word_t                           pwdata_i,
  output dbg_pkg::apb_word_t                           prdata_o,
  output logic                                         pready_o,
  output logic                                         pslverr_o
);

  import dbg_pkg::*;

  logic [`DBG_STAT_W-1:0]  flags;
  logic [`DBG_STAT_W-1:0]  flag_clr;
  logic                    cnt_clr;
  dbg_cap_cfg_u            cap_cfg;
  logic [`DBG_CNT_W-1:0]   sm_count;
  logic [`DBG_SPPE_W-1:0]  cap_a;
  logic [`DBG_SPPE_W-1:0]  cap_b;

  // ==============================
  // Input side
  // ==============================
  dbg_flag_sampler u_sampler (
    .clk         (clk),
    .rst_n       (rst_n),
    .spmm_vld_i  (spmm_vld_i),
    .spmm_rdy_i  (spmm_rdy_i),
    .dmvm_vld_i  (dmvm_vld_i),
    .dmvm_rdy_i  (dmvm_rdy_i),
    .sm_vld_i    (sm_vld_i),
    .sm_rdy_i    (sm_rdy_i),
    .aggr_vld_i  (aggr_vld_i),
    .aggr_rdy_i  (aggr_rdy_i),
    .feat_ena_i  (feat_ena_i),
    .feat_addr_i (feat_addr_i),
    .flag_clr_i  (flag_clr),
    .flags_o     (flags)
  );

  dbg_probe_capture u_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .sm_vld_i   (sm_vld_i),
    .spmm_rdy_i (spmm_rdy_i),
    .wh_addr_i  (wh_addr_i),
    .sppe_i     (sppe_i),
    .cnt_clr_i  (cnt_clr),
    .cap_cfg_i  (cap_cfg),
    .sm_count_o (sm_count),
    .cap_a_o    (cap_a),
    .cap_b_o    (cap_b)
  );

  // ==============================
  // Software view
  // ==============================
  dbg_apb_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .flags_i    (flags),
    .sm_count_i (sm_count),
    .cap_a_i    (cap_a),
    .cap_b_i    (cap_b),
    .flag_clr_o (flag_clr),
    .cnt_clr_o  (cnt_clr),
    .cap_cfg_o  (cap_cfg)
  );

endmodule

`default_nettype wire

// ==== tb_dbg_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_macros.svh"

module tb_dbg_monitor;

  import dbg_pkg::*;

  localparam int DRIVE_DLY  = 2;
  localparam int WAIT_LIMIT = 20;  // Cycles allowed for pready

  logic                                        clk;
  logic                                        rst_n;
  logic                                        spmm_vld;
  logic                                        spmm_rdy;
  logic                                        dmvm_vld;
  logic                                        dmvm_rdy;
  logic                                        sm_vld;
  logic                                        sm_rdy;
  logic                                        aggr_vld;
  logic                                        aggr_rdy;
  logic                                        feat_ena;
  logic [`DBG_FEAT_ADDR_W-1:0]                 feat_addr;
  logic [`DBG_WH_ADDR_W-1:0]                   wh_addr;
  logic [`DBG_SPPE_LANES-1:0][`DBG_SPPE_W-1:0] sppe;
  logic                                        psel;
  logic                                        penable;
  logic                                        pwrite;
  logic [`DBG_APB_ADDR_W-1:0]                  paddr;
  apb_word_t                                   pwdata;
  apb_word_t                                   prdata;
  logic                                        pready;
  logic                                        pslverr;
  logic [`DBG_LANE_SEL_W-1:0]                  probe_lane;  // Lane the capture unit watches

  dbg_monitor_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .spmm_vld_i(spmm_vld), .spmm_rdy_i(spmm_rdy),
    .dmvm_vld_i(dmvm_vld), .dmvm_rdy_i(dmvm_rdy),
    .sm_vld_i(sm_vld), .sm_rdy_i(sm_rdy),
    .aggr_vld_i(aggr_vld), .aggr_rdy_i(aggr_rdy),
    .feat_ena_i(feat_ena), .feat_addr_i(feat_addr),
    .wh_addr_i(wh_addr), .sppe_i(sppe),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==============================
  // Failure and compare tasks
  // ==============================
  task automatic abort_run(input string why);
    $display("%0s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input apb_word_t exp, input apb_word_t act);
    if (act !== exp)
      abort_run($sformatf("Mismatch %0s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_cap_cfg(input string name, input dbg_cap_cfg_u exp,
                               input dbg_cap_cfg_u act);
    if (act.fields !== exp.fields)
      abort_run($sformatf("Mismatch %0s: expected a=%h b=%h lane=%h, actual a=%h b=%h lane=%h",
                          name, exp.fields.addr_a, exp.fields.addr_b, exp.fields.lane_sel,
                          act.fields.addr_a, act.fields.addr_b, act.fields.lane_sel));
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("Mismatch %0s: expected pslverr %b, actual %b", name, exp, act));
  endtask

  // ==============================
  // Drivers
  // ==============================
  task automatic drive_strobes(input logic [7:0] strb, input logic ena,
                               input logic [`DBG_FEAT_ADDR_W-1:0] faddr,
                               input logic [`DBG_WH_ADDR_W-1:0] waddr,
                               input logic [`DBG_SPPE_W-1:0] lane, input int cycles);
    logic [31:0] rnd;
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} = strb;
    feat_ena  = ena;
    feat_addr = faddr;
    wh_addr   = waddr;
    repeat (cycles) begin
      for (int l = 0; l < `DBG_SPPE_LANES; l++) begin
        rnd     = $urandom;
        sppe[l] = rnd[`DBG_SPPE_W-1:0];  // Idle lanes carry noise
      end
      sppe[probe_lane] = lane;
      @(posedge clk);
      #DRIVE_DLY;
    end
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} = '0;
    feat_ena = 1'b0;
  endtask

  task automatic apb_access(input logic wr, input logic [`DBG_APB_ADDR_W-1:0] addr,
                            input apb_word_t wdata, output apb_word_t rdata, output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run($sformatf("APB transfer to offset %h never saw pready", addr));
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // ==============================
  // Record player
  // ==============================
  initial begin
    int                          fd;
    int                          n;
    int                          n_reads;
    int                          cycles;
    string                       line;
    string                       name;
    byte                         kind;
    logic [8*24-1:0]             tag;
    logic [7:0]                  strb;
    logic                        ena;
    logic [`DBG_FEAT_ADDR_W-1:0] faddr;
    logic [`DBG_WH_ADDR_W-1:0]   waddr;
    logic [`DBG_SPPE_W-1:0]      lane;
    logic [`DBG_APB_ADDR_W-1:0]  offs;
    apb_word_t                   data;
    apb_word_t                   rd;
    logic                        err_exp;
    logic                        err;
    dbg_cap_cfg_u                cfg_exp;
    dbg_cap_cfg_u                cfg_act;

    void'($urandom(10));
    n_reads = 0;
    rst_n = 1'b0;
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} = '0;
    feat_ena   = 1'b0;
    feat_addr  = '0;
    wh_addr    = '0;
    sppe       = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    probe_lane = '0;
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    fd = $fopen("dbg_input_vectors.txt", "r");
    if (fd == 0)
      abort_run("Could not open dbg_input_vectors.txt");
    while ($fgets(line, fd) != 0) begin
      kind = line.getc(0);
      if (kind == "S") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %d",
                    strb, ena, faddr, waddr, lane, cycles);
        if (n != 6)
          abort_run({"Malformed strobe record: ", line});
        drive_strobes(strb, ena, faddr, waddr, lane, cycles);
      end else if (kind == "W" || kind == "R") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%s %h %h %h", tag, offs, data, err_exp);
        if (n != 4)
          abort_run({"Malformed APB record: ", line});
        name = $sformatf("%0s", tag);
        apb_access(kind == "W", offs, data, rd, err);
        check_err(name, err_exp, err);
        if (kind == "W" && !err_exp && offs == `DBG_REG_CAP_CFG) begin
          cfg_exp.raw = data;
          probe_lane  = cfg_exp.fields.lane_sel;
        end else if (kind == "R" && !err_exp) begin
          n_reads++;
          if (offs == `DBG_REG_CAP_CFG) begin
            cfg_exp.raw = data;
            cfg_act.raw = rd;
            check_cap_cfg(name, cfg_exp, cfg_act);
          end else begin
            check_word(name, data, rd);
          end
        end
      end else if (kind != "#" && kind != "\n" && kind != "\r" && kind != " ") begin
        abort_run({"Unknown record kind in line: ", line});
      end
    end
    $fclose(fd);

    if (n_reads == 0) begin
      abort_run("The data file held no read checks");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dbg_input_vectors.txt ====
# S strobes(spmm_vld..aggr_rdy, MSB first) feat_ena feat_addr wh_addr lane_val cycles(decimal)
# W name offset wdata exp_pslverr | R name offset exp_rdata exp_pslverr ; other numbers hex
R id_reset 00 00D88F77 0
R config_reset 04 0000000C 0
R status_reset 08 00000000 0
R cnt_lo_reset 0C 00000000 0
R cnt_hi_reset 10 00000000 0
R cap_a_reset 18 00000000 0
R cap_b_reset 1C 00000000 0
S AA 0 0000 0000 000 1
S 55 0 0000 0000 000 1
S 00 0 0000 0000 000 3
R status_strobes 08 000000FF 0
W clear_upper 08 000000F0 0
R status_lower 08 0000000F 0
W clear_lower 08 0000000F 0
R status_cleared 08 00000000 0
S 00 1 A93F 0000 000 1
R feat_below 08 00000100 0
W clear_feat 08 00000300 0
S 00 1 A940 0000 000 1
R feat_limit 08 00000300 0
W cnt_clear 0C 00000000 0
S 08 0 0000 0000 000 25
R cnt_lo_25 0C 00000019 0
R cnt_hi_25 10 00000000 0
W cnt_clear_again 0C 12345678 0
R cnt_lo_cleared 0C 00000000 0
W cap_cfg 14 048EABC5 0
R cap_cfg_readback 14 048EABC5 0
S 40 0 0000 0123 7A1 1
S 40 0 0000 2ABC 3C4 1
S 40 0 0000 0100 FFF 2
S 00 0 0000 0123 555 1
R cap_a_hit 18 000007A1 0
R cap_b_hit 1C 000003C4 0
S 40 0 0000 0123 0B2 1
R cap_a_again 18 000000B2 0
R cap_b_kept 1C 000003C4 0
R unmapped_read 20 00000000 1
W id_write 00 00000000 1
W unmapped_write 24 FFFFFFFF 1
W cap_a_write 18 00000000 1
R cap_cfg_kept 14 048EABC5 0
R id_kept 00 00D88F77 0

// ==== vlog.f ====
+incdir+.
dbg_pkg.sv
dbg_flag_sampler.sv
dbg_probe_capture.sv
dbg_apb_regs.sv
dbg_monitor_top.sv
tb_dbg_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the debug monitor testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module tb_dbg_monitor \
  -o sim_dbg_monitor &&
./obj_dir/sim_dbg_monitor ||
{
  echo "Simulation build or run failed"
  exit 1
}
